/* design/xv_defines.svh */
// size parameters of the video memory subsystem
// included by the package and by every module that sizes a port from them

`ifndef XV_DEFINES_SVH
`define XV_DEFINES_SVH

`define XV_WORD_W   16  // bits per vram word
`define XV_ADDR_W   16  // word address, 64K words in total

// four equal banks, selected by the top address bits
`define XV_BANKS    4
`define XV_BANK_AW  14  // 16K words per bank

`endif

/* design/xv_pkg.sv */
// common types for the vram subsystem
// modules import it in their body and use scoped names in port lists

`include "xv_defines.svh"

package xv_pkg;

    typedef logic [`XV_WORD_W-1:0] word_t;
    typedef logic [`XV_ADDR_W-1:0] addr_t;

    // bit n enables bits 4n+3..4n of the word
    typedef logic [`XV_WORD_W/4-1:0] mask_t;

    typedef logic [$clog2(`XV_BANKS)-1:0] bank_t;  // address bits 15:14

    // which client a returning read belongs to
    typedef enum logic {
        src_host  = 1'b0,
        src_video = 1'b1
    } src_t;

endpackage

/* design/host_port.sv */
// host side of the vram, a four-phase req/ack slave
// each req handshake becomes exactly one access through the arbiter;
// host_ack rises with host_rdata valid and drops after req falls

`timescale 1ns/1ps

module host_port (
    input  logic          clk,
    input  logic          rst,
    // host handshake
    input  logic          host_req,
    input  logic          host_we,
    input  xv_pkg::addr_t host_addr,
    input  xv_pkg::mask_t host_mask,
    input  xv_pkg::word_t host_wdata,
    output logic          host_ack,
    output xv_pkg::word_t host_rdata,
    // towards the arbiter
    output logic          mem_req,
    output logic          mem_we,
    output xv_pkg::addr_t mem_addr,
    output xv_pkg::mask_t mem_mask,
    output xv_pkg::word_t mem_wdata,
    input  logic          mem_gnt,
    // return path from the read mux
    input  logic          host_rvalid,
    input  xv_pkg::word_t host_rdata_in
);

    typedef enum logic [1:0] {
        st_idle,
        st_busy,  // waiting for grant, then for the returned word
        st_ack    // ack held until host drops req
    } state_t;

    state_t state;

    // st_ack only exits once req is low, so req seen in st_idle is always
    // a fresh rising edge
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            host_ack <= 1'b0;
            mem_req  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (host_req) begin
                        mem_req <= 1'b1;
                        state   <= st_busy;
                    end
                end
                st_busy: begin
                    if (mem_gnt) mem_req <= 1'b0;  // one grant per handshake
                    if (host_rvalid) begin
                        host_ack <= 1'b1;
                        state    <= st_ack;
                    end
                end
                st_ack: begin
                    if (!host_req) begin
                        host_ack <= 1'b0;
                        state    <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // command and returned word
    always_ff @(posedge clk) begin
        if (state == st_idle && host_req) begin
            mem_we    <= host_we;
            mem_addr  <= host_addr;
            mem_mask  <= host_mask;
            mem_wdata <= host_wdata;
        end
        if (state == st_busy && host_rvalid) host_rdata <= host_rdata_in;
    end

endmodule

/* design/vram_arbiter.sv */
// front end of the vram, one access per cycle
// scanout has fixed priority and the host waits while video_req is high;
// the bank and client of each access are registered for the read mux

`timescale 1ns/1ps

`include "xv_defines.svh"

module vram_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    // scanout client
    input  logic                   video_req,
    input  xv_pkg::addr_t          video_addr,
    // host client
    input  logic                   mem_req,
    input  logic                   mem_we,
    input  xv_pkg::addr_t          mem_addr,
    input  xv_pkg::mask_t          mem_mask,
    input  xv_pkg::word_t          mem_wdata,
    output logic                   mem_gnt,
    // shared bank bus
    output logic [`XV_BANKS-1:0]   bank_sel,
    output logic [`XV_BANK_AW-1:0] bank_addr,
    output logic                   bank_we,
    output xv_pkg::mask_t          bank_mask,
    output xv_pkg::word_t          bank_wdata,
    // return tag, one cycle after the grant
    output logic                   ret_valid,
    output xv_pkg::bank_t          ret_bank,
    output xv_pkg::src_t           ret_src
);

    import xv_pkg::*;

    logic  host_win;
    logic  any_access;
    addr_t acc_addr;
    bank_t acc_bank;

    assign host_win   = mem_req && !video_req;  // host only gets idle slots
    assign mem_gnt    = host_win;
    assign any_access = video_req || host_win;

    assign acc_addr = video_req ? video_addr : mem_addr;
    assign acc_bank = acc_addr[`XV_ADDR_W-1 -: $bits(bank_t)];

    always_comb begin
        bank_sel = '0;
        if (any_access) bank_sel[acc_bank] = 1'b1;
    end

    assign bank_addr  = acc_addr[`XV_BANK_AW-1:0];
    assign bank_we    = host_win && mem_we;  // scanout never writes
    assign bank_mask  = mem_mask;
    assign bank_wdata = mem_wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            ret_valid <= 1'b0;
        end else begin
            ret_valid <= any_access;
        end
    end

    always_ff @(posedge clk) begin
        ret_bank <= acc_bank;
        ret_src  <= video_req ? src_video : src_host;
    end

endmodule

/* design/vram_bank.sv */
// one 16K-word vram bank as an inferred single-port array
// nibble-masked write; the word stored before the write is
// registered onto rdata in the same cycle

`timescale 1ns/1ps

`include "xv_defines.svh"

module vram_bank (
    input  logic                   clk,
    input  logic                   sel,
    input  logic                   we,
    input  xv_pkg::mask_t          mask,
    input  logic [`XV_BANK_AW-1:0] addr,
    input  xv_pkg::word_t          wdata,
    output xv_pkg::word_t          rdata
);

    import xv_pkg::*;

    word_t mem [0:(1 << `XV_BANK_AW)-1];

    // memory comes up cleared
    initial begin
        for (int i = 0; i < (1 << `XV_BANK_AW); i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (sel) begin
            for (int n = 0; n < $bits(mask_t); n++) begin
                if (we && mask[n]) mem[addr][4*n +: 4] <= wdata[4*n +: 4];
            end
            rdata <= mem[addr];  // old word, read before write
        end
    end

endmodule

/* design/vram_read_mux.sv */
// read return path of the vram
// picks the word of the bank that was accessed last cycle and
// hands it to scanout or host, as named by the registered tag

`timescale 1ns/1ps

`include "xv_defines.svh"

module vram_read_mux (
    input  logic          ret_valid,
    input  xv_pkg::bank_t ret_bank,
    input  xv_pkg::src_t  ret_src,
    input  xv_pkg::word_t bank_rdata [`XV_BANKS],
    // scanout return
    output logic          video_valid,
    output xv_pkg::word_t video_data,
    // host return
    output logic          host_rvalid,
    output xv_pkg::word_t host_rdata
);

    import xv_pkg::*;

    word_t ret_word;

    assign ret_word = bank_rdata[ret_bank];

    // strobe goes only to the client that issued the access
    always_comb begin
        video_valid = 1'b0;
        host_rvalid = 1'b0;
        if (ret_valid) begin
            case (ret_src)
                src_video: video_valid = 1'b1;
                src_host:  host_rvalid = 1'b1;
                default:   host_rvalid = 1'b0;
            endcase
        end
    end

    assign video_data = ret_word;
    assign host_rdata = ret_word;

endmodule

/* design/xosera_vram.sv */
// top of the video memory subsystem, 64K words in four banks
// host side is a four-phase req/ack port, scanout side a fixed
// one-cycle read pipe with priority over the host

`timescale 1ns/1ps

`include "xv_defines.svh"

module xosera_vram (
    input  logic          clk,
    input  logic          rst,
    // host handshake
    input  logic          host_req,
    input  logic          host_we,
    input  xv_pkg::addr_t host_addr,
    input  xv_pkg::mask_t host_mask,
    input  xv_pkg::word_t host_wdata,
    output logic          host_ack,
    output xv_pkg::word_t host_rdata,
    // scanout
    input  logic          video_req,
    input  xv_pkg::addr_t video_addr,
    output logic          video_valid,
    output xv_pkg::word_t video_data
);

    import xv_pkg::*;

    // host_port to arbiter
    logic  mem_req;
    logic  mem_we;
    addr_t mem_addr;
    mask_t mem_mask;
    word_t mem_wdata;
    logic  mem_gnt;

    // shared bank bus
    logic [`XV_BANKS-1:0]   bank_sel;
    logic [`XV_BANK_AW-1:0] bank_addr;
    logic                   bank_we;
    mask_t                  bank_mask;
    word_t                  bank_wdata;
    word_t                  bank_rdata [`XV_BANKS];

    // return tag and host read data
    logic  ret_valid;
    bank_t ret_bank;
    src_t  ret_src;
    logic  host_rvalid;
    word_t host_rdata_ret;

    host_port u_host_port (
        .clk           (clk),
        .rst           (rst),
        .host_req      (host_req),
        .host_we       (host_we),
        .host_addr     (host_addr),
        .host_mask     (host_mask),
        .host_wdata    (host_wdata),
        .host_ack      (host_ack),
        .host_rdata    (host_rdata),
        .mem_req       (mem_req),
        .mem_we        (mem_we),
        .mem_addr      (mem_addr),
        .mem_mask      (mem_mask),
        .mem_wdata     (mem_wdata),
        .mem_gnt       (mem_gnt),
        .host_rvalid   (host_rvalid),
        .host_rdata_in (host_rdata_ret)
    );

    vram_arbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .video_req  (video_req),
        .video_addr (video_addr),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_mask   (mem_mask),
        .mem_wdata  (mem_wdata),
        .mem_gnt    (mem_gnt),
        .bank_sel   (bank_sel),
        .bank_addr  (bank_addr),
        .bank_we    (bank_we),
        .bank_mask  (bank_mask),
        .bank_wdata (bank_wdata),
        .ret_valid  (ret_valid),
        .ret_bank   (ret_bank),
        .ret_src    (ret_src)
    );

    for (genvar i = 0; i < `XV_BANKS; i++) begin : g_bank
        vram_bank u_bank (
            .clk   (clk),
            .sel   (bank_sel[i]),
            .we    (bank_we),
            .mask  (bank_mask),
            .addr  (bank_addr),
            .wdata (bank_wdata),
            .rdata (bank_rdata[i])
        );
    end

    vram_read_mux u_read_mux (
        .ret_valid   (ret_valid),
        .ret_bank    (ret_bank),
        .ret_src     (ret_src),
        .bank_rdata  (bank_rdata),
        .video_valid (video_valid),
        .video_data  (video_data),
        .host_rvalid (host_rvalid),
        .host_rdata  (host_rdata_ret)
    );

endmodule

/* sim/vram_checker.sv */
// scoreboard for the vram testbench
// samples the DUT ports on the rising edge, queues the expected read data,
// checks the four-phase host order and the one-cycle scanout latency

`timescale 1ns/1ps

module vram_checker (
    input  logic          clk,
    input  logic          rst,
    input  logic          host_req,
    input  logic          host_ack,
    input  xv_pkg::word_t host_rdata,
    input  xv_pkg::word_t host_exp,   // taken when host_req rises
    input  logic          video_req,
    input  xv_pkg::word_t video_exp,  // taken with every video_req
    input  logic          video_valid,
    input  xv_pkg::word_t video_data,
    input  logic          report,
    output logic          reported,
    output int            err_count
);

    import xv_pkg::*;

    word_t host_q [$];
    word_t video_q [$];
    word_t want;
    int    errors   = 0;
    int    n_checks = 0;
    logic  done     = 1'b0;
    logic  prev_req = 1'b0;
    logic  prev_ack = 1'b0;
    logic  req_d    = 1'b0;  // video_req one edge back
    logic  rst_d    = 1'b0;

    assign err_count = errors;
    assign reported  = done;

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic match_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic log_fault(input string what);
        errors++;
        $display("failure at %0d ns: %s", $time, what);
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (rst_d) begin  // first edge after reset
                match_bit("host_ack", host_ack, 1'b0);
                match_bit("video_valid", video_valid, 1'b0);
            end
            // ack is set on the edge after req was seen, so compare with prev_req
            if (host_req && !prev_req) begin
                if (host_ack) log_fault("host_req rose while host_ack was still high");
                host_q.push_back(host_exp);
            end
            if (!host_req && prev_req && !host_ack) log_fault("host_req fell before host_ack");
            if (host_ack && !prev_ack) begin
                if (!prev_req) log_fault("host_ack rose without host_req");
                if (host_q.size() == 0) begin
                    log_fault("host_ack with no open host request");
                end else begin
                    want = host_q.pop_front();
                    compare_word("host_rdata", host_rdata, want);
                end
            end
            if (!host_ack && prev_ack && prev_req) log_fault("host_ack fell while host_req was high");

            // scanout returns exactly one cycle after the request
            match_bit("video_valid", video_valid, req_d);
            if (req_d && video_q.size() > 0) begin
                want = video_q.pop_front();
                if (video_valid) compare_word("video_data", video_data, want);
            end
            if (video_req) video_q.push_back(video_exp);
        end
        if (report && !done) begin
            if (host_q.size() != 0) log_fault("host requests left without host_ack");
            if (video_q.size() != 0) log_fault("scanout reads left without video_valid");
            $display("checks: %0d, errors: %0d", n_checks, errors);
            done = 1'b1;
        end
        prev_req = host_req;
        prev_ack = host_ack;
        req_d    = video_req && !rst;
        rst_d    = rst;
    end

endmodule

/* sim/vram_tb.sv */
// testbench for the vram subsystem
// reads host operations and scanout reads from sim/vram_stimulus.txt and runs
// the host ops under random scanout traffic, then a back-to-back scanout burst;
// vram_checker does the comparing and counts the errors

`timescale 1ns/1ps

module vram_tb;

    import xv_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int RST_CYCLES      = 8;
    localparam int CYCLES_PER_LINE = 64;

    logic       clk;
    logic       rst;
    logic       host_req;
    logic       host_we;
    addr_t      host_addr;
    logic [3:0] host_mask;
    word_t      host_wdata;
    logic       host_ack;
    word_t      host_rdata;
    logic       video_req;
    addr_t      video_addr;
    logic       video_valid;
    word_t      video_data;

    word_t host_exp;   // travels with host_req to the checker
    word_t video_exp;  // travels with video_req
    logic  report;
    logic  reported;
    int    err_count;

    // operations as read from the file
    logic       hq_we [$];
    addr_t      hq_addr [$];
    logic [3:0] hq_mask [$];
    word_t      hq_wdata [$];
    word_t      hq_exp [$];
    addr_t      vq_addr [$];
    word_t      vq_exp [$];

    int     n_lines = 0;
    logic   loaded  = 1'b0;
    integer seed    = 32'hc009;

    xosera_vram DUT (
        .clk(clk), .rst(rst),
        .host_req(host_req), .host_we(host_we), .host_addr(host_addr),
        .host_mask(host_mask), .host_wdata(host_wdata),
        .host_ack(host_ack), .host_rdata(host_rdata),
        .video_req(video_req), .video_addr(video_addr),
        .video_valid(video_valid), .video_data(video_data)
    );

    vram_checker u_checker (
        .clk(clk), .rst(rst),
        .host_req(host_req), .host_ack(host_ack), .host_rdata(host_rdata),
        .host_exp(host_exp),
        .video_req(video_req), .video_exp(video_exp),
        .video_valid(video_valid), .video_data(video_data),
        .report(report), .reported(reported), .err_count(err_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic load_stimulus(output bit ok);
        int          fd;
        int          cnt;
        string       line;
        logic [15:0] f_we, f_addr, f_mask, f_wdata, f_exp;
        ok = 1'b1;
        fd = $fopen("sim/vram_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/vram_stimulus.txt");
            ok = 1'b0;
        end else begin
            while (!$feof(fd)) begin
                cnt = $fgets(line, fd);
                if (cnt > 0 && line.getc(0) == "H") begin
                    cnt = $sscanf(line, "H %h %h %h %h %h", f_we, f_addr, f_mask, f_wdata, f_exp);
                    if (cnt != 5) ok = 1'b0;
                    hq_we.push_back(f_we[0]);
                    hq_addr.push_back(f_addr);
                    hq_mask.push_back(f_mask[3:0]);
                    hq_wdata.push_back(f_wdata);
                    hq_exp.push_back(f_exp);
                    n_lines++;
                end else if (cnt > 0 && line.getc(0) == "V") begin
                    cnt = $sscanf(line, "V %h %h", f_addr, f_exp);
                    if (cnt != 2) ok = 1'b0;
                    vq_addr.push_back(f_addr);
                    vq_exp.push_back(f_exp);
                    n_lines++;
                end
            end
            $fclose(fd);
            if (!ok) $display("malformed line in sim/vram_stimulus.txt");
        end
    endtask

    // background reads, only from c000..c0ff which the host never writes
    task automatic scanout_noise();
        int r;
        r = $random(seed);
        video_req  = (r[1:0] != 2'b00);  // busy on most cycles
        video_addr = {8'hc0, r[15:8]};
        video_exp  = '0;
    endtask

    // one full four-phase handshake, scanout noise on every cycle
    task automatic host_access(input int i);
        int hold;
        @(negedge clk);
        host_we    = hq_we[i];
        host_addr  = hq_addr[i];
        host_mask  = hq_mask[i];
        host_wdata = hq_wdata[i];
        host_exp   = hq_exp[i];
        host_req   = 1'b1;
        scanout_noise();
        while (!host_ack) begin
            @(negedge clk);
            scanout_noise();
        end
        hold = $random(seed) & 3;  // req stays up a few cycles past ack
        repeat (hold) begin
            @(negedge clk);
            scanout_noise();
        end
        host_req = 1'b0;
        while (host_ack) begin
            @(negedge clk);
            scanout_noise();
        end
    endtask

    task automatic scanout_burst();
        foreach (vq_addr[i]) begin
            @(negedge clk);
            video_req  = 1'b1;
            video_addr = vq_addr[i];
            video_exp  = vq_exp[i];
        end
        @(negedge clk);
        video_req = 1'b0;
    endtask

    initial begin
        bit ok;
        rst        = 1'b1;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_mask  = '0;
        host_wdata = '0;
        host_exp   = '0;
        video_req  = 1'b0;
        video_addr = '0;
        video_exp  = '0;
        report     = 1'b0;
        load_stimulus(ok);
        if (!ok) begin
            $display("Finished with errors");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (RST_CYCLES) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            for (int i = 0; i < hq_we.size(); i++) host_access(i);
            scanout_burst();
            repeat (2) @(negedge clk);  // let the last return drain
            report = 1'b1;
            while (!reported) @(negedge clk);
            if (err_count == 0) begin
                $display("Finished with no errors");
            end else begin
                $display("Finished with errors");
            end
            $finish;
        end
    end

    // watchdog
    initial begin
        int limit;
        wait (loaded);
        limit = RST_CYCLES + n_lines * CYCLES_PER_LINE;
        repeat (limit) @(posedge clk);
        $display("timeout after %0d cycles, a handshake or read return never completed", limit);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* sim/vram_stimulus.txt */
# H we addr mask wdata expected_host_rdata  (hex; a write returns the word stored before it)
# V addr expected_video_data                (hex; scanout burst after the host ops)
H 0 0010 0 0000 0000
H 0 4010 0 0000 0000
H 1 0010 f 1234 0000
H 0 0010 0 0000 1234
H 1 0010 f abcd 1234
H 0 0010 0 0000 abcd
H 1 0010 3 5678 abcd
H 0 0010 0 0000 ab78
H 1 0010 8 f000 ab78
H 0 0010 0 0000 fb78
H 1 0010 6 0990 fb78
H 0 0010 0 0000 f998
H 1 0123 f 1111 0000
H 1 4123 f 2222 0000
H 1 8123 f 3333 0000
H 1 c123 f 4444 0000
H 0 0123 0 0000 1111
H 0 4123 0 0000 2222
H 0 8123 0 0000 3333
H 0 c123 0 0000 4444
H 1 8123 5 a0b0 3333
H 0 8123 0 0000 3030
H 1 ffff c 9a00 0000
H 0 ffff 0 0000 9a00
V 0010 f998
V 0123 1111
V 4123 2222
V 8123 3030
V c123 4444
V ffff 9a00
V c000 0000

/* xosera_vram.f */
+incdir+design
design/xv_pkg.sv
design/host_port.sv
design/vram_arbiter.sv
design/vram_bank.sv
design/vram_read_mux.sv
design/xosera_vram.sv
sim/vram_checker.sv
sim/vram_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the vram testbench with verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f xosera_vram.f --top-module vram_tb -o vram_sim \
    && ./obj_dir/vram_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "^Finished with no errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
